//--- logic/codec_init_pkg.sv
package codec_init_pkg;

	localparam int CMD_WIDTH  = 24;  // Address byte plus two register bytes
	localparam int BYTE_WIDTH = 8;   // Bits between acknowledge slots
	localparam int NUM_CMDS   = 11;  // Entries in the bring-up table

	typedef logic [CMD_WIDTH-1:0] cmd_word_t;  // One framed command
	typedef logic [3:0]           cmd_idx_t;   // Pointer into CODEC_CMDS

	// Power-on register list for the codec, sent in this order
	localparam cmd_word_t CODEC_CMDS [NUM_CMDS] = '{
		24'h341E00,  // Reset
		24'h340097,  // Left line in
		24'h340297,  // Right line in
		24'h340479,  // Left headphone out
		24'h340679,  // Right headphone out
		24'h340815,  // Analog path
		24'h340A00,  // Digital path
		24'h340C00,  // Power down
		24'h340E42,  // Interface format
		24'h341019,  // Sampling control
		24'h341201   // Active control
	};

	// Writer FSM, every bus bit is four quarter ticks
	typedef enum logic [2:0] {
		WR_IDLE,     // Bus released, SCL and SDA high
		WR_START,    // SDA falls while SCL high
		WR_BIT_LO,   // SCL low, data set up
		WR_BIT_HI,   // SCL high, data stable
		WR_ACK_LO,   // Line released for the codec
		WR_ACK_HI,   // Ack sampled at end of this half
		WR_STOP_LO,  // SDA pulled low ahead of stop
		WR_STOP_HI   // SDA rises while SCL high
	} wr_state_t;

endpackage

//--- logic/i2c_quarter_timer.sv
module i2c_quarter_timer #(
	parameter int CLK_DIV = 4  // Clock cycles per quarter bit
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_run,   // Writer busy
	output logic o_tick   // One cycle per quarter bit
);

	// At least one bit so a divide of one still has a counter
	localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CW-1:0] cnt, cnt_nxt;  // Cycles into the current quarter
	logic          wrap;          // Last cycle of a quarter

	assign wrap   = (cnt == CW'(CLK_DIV - 1));
	assign o_tick = i_run && wrap;  // Only counts while a word is on the bus

	always_comb begin
		cnt_nxt = cnt;
		if (!i_run) begin
			cnt_nxt = '0;  // Idle restarts the quarter
		end
		else if (wrap) begin
			cnt_nxt = '0;
		end
		else begin
			cnt_nxt = cnt + 1'b1;
		end
	end

	// First tick lands CLK_DIV cycles after i_run rises
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end
		else begin
			cnt <= cnt_nxt;
		end
	end

endmodule

//--- logic/i2c_word_writer.sv
module i2c_word_writer import codec_init_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_send,   // Strobe, ignored while busy
	input  cmd_word_t i_word,   // Command latched with i_send
	input  logic      i_tick,   // Quarter-bit tick
	input  logic      i_ack,    // Sampled data line
	output logic      o_busy,   // Word in flight, runs the timer
	output logic      o_done,   // Pulse after stop
	output logic      o_nack,   // Valid with o_done
	output logic      o_sclk,
	output logic      o_sdat,
	output logic      o_oen     // High while driving SDA
);

	localparam int BW = $clog2(CMD_WIDTH);

	wr_state_t state, state_nxt;
	logic [1:0]    qtr, qtr_nxt;          // Quarter within the bus bit
	logic [BW-1:0] bit_cnt, bit_cnt_nxt;  // Data bit being sent
	cmd_word_t     sh, sh_nxt;            // MSB goes out first
	logic          scl_r, scl_nxt;
	logic          sda_r, sda_nxt;
	logic          nack_r, nack_nxt;      // Sticky over all three acks
	logic          done_r, done_nxt;
	logic          byte_end;              // Ack slot follows this bit
	logic          last_bit;              // Stop follows next ack

	assign byte_end = ((bit_cnt % BYTE_WIDTH) == BYTE_WIDTH - 1);
	assign last_bit = (bit_cnt == BW'(CMD_WIDTH - 1));

	assign o_busy = (state != WR_IDLE);
	assign o_done = done_r;
	assign o_nack = nack_r;
	assign o_sclk = scl_r;
	assign o_sdat = sda_r;
	// Release SDA when idle and for the codec's acknowledge
	assign o_oen  = !(state == WR_IDLE || state == WR_ACK_LO || state == WR_ACK_HI);

	always_comb begin
		state_nxt   = state;
		qtr_nxt     = qtr;
		bit_cnt_nxt = bit_cnt;
		sh_nxt      = sh;
		scl_nxt     = scl_r;
		sda_nxt     = sda_r;
		nack_nxt    = nack_r;
		done_nxt    = 1'b0;

		if (state == WR_IDLE) begin
			if (i_send) begin
				state_nxt   = WR_START;
				qtr_nxt     = '0;
				bit_cnt_nxt = '0;
				sh_nxt      = i_word;
				nack_nxt    = 1'b0;  // Fresh word, fresh flag
			end
		end
		else if (i_tick) begin
			qtr_nxt = qtr + 1'b1;  // Wraps every four ticks
			case (state)
			WR_START: begin
				if (qtr == 2'd1) begin
					sda_nxt = 1'b0;  // Start condition, SCL still high
				end
				if (qtr == 2'd3) begin
					scl_nxt   = 1'b0;
					state_nxt = WR_BIT_LO;
				end
			end
			WR_BIT_LO: begin
				if (qtr == 2'd0) begin
					sda_nxt = sh[CMD_WIDTH-1];  // Data moves mid low phase
				end
				else begin
					scl_nxt   = 1'b1;
					state_nxt = WR_BIT_HI;
				end
			end
			WR_BIT_HI: begin
				if (qtr == 2'd3) begin
					scl_nxt = 1'b0;
					sh_nxt  = sh << 1;
					if (byte_end) begin
						state_nxt = WR_ACK_LO;  // Every eighth bit
					end
					else begin
						bit_cnt_nxt = bit_cnt + 1'b1;
						state_nxt   = WR_BIT_LO;
					end
				end
			end
			WR_ACK_LO: begin
				if (qtr == 2'd0) begin
					sda_nxt = 1'b1;  // Released level
				end
				else begin
					scl_nxt   = 1'b1;
					state_nxt = WR_ACK_HI;
				end
			end
			WR_ACK_HI: begin
				if (qtr == 2'd3) begin
					nack_nxt = nack_r | i_ack;  // High line means refused
					scl_nxt  = 1'b0;
					if (last_bit) begin
						state_nxt = WR_STOP_LO;
					end
					else begin
						bit_cnt_nxt = bit_cnt + 1'b1;
						state_nxt   = WR_BIT_LO;
					end
				end
			end
			WR_STOP_LO: begin
				if (qtr == 2'd0) begin
					sda_nxt = 1'b0;  // Low before SCL rises
				end
				else begin
					scl_nxt   = 1'b1;
					state_nxt = WR_STOP_HI;
				end
			end
			WR_STOP_HI: begin
				if (qtr == 2'd2) begin
					sda_nxt = 1'b1;  // Stop condition
				end
				if (qtr == 2'd3) begin
					done_nxt  = 1'b1;
					state_nxt = WR_IDLE;
				end
			end
			default: state_nxt = WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= WR_IDLE;
			qtr     <= '0;
			bit_cnt <= '0;
			scl_r   <= 1'b1;  // Bus rests high
			sda_r   <= 1'b1;
			nack_r  <= 1'b0;
			done_r  <= 1'b0;
		end
		else begin
			state   <= state_nxt;
			qtr     <= qtr_nxt;
			bit_cnt <= bit_cnt_nxt;
			scl_r   <= scl_nxt;
			sda_r   <= sda_nxt;
			nack_r  <= nack_nxt;
			done_r  <= done_nxt;
		end
	end

	// Shift data only
	always_ff @(posedge i_clk) begin
		sh <= sh_nxt;
	end

endmodule

//--- logic/init_sequencer.sv
module init_sequencer import codec_init_pkg::*; #(
	parameter int MAX_RETRIES = 2  // Resends per refused command
) (
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_start,     // Pulse, ignored mid-run
	input  logic      i_done,      // Writer finished a word
	input  logic      i_nack,      // Valid with i_done
	output logic      o_send,      // Strobe to the writer
	output cmd_word_t o_word,      // Table entry under the pointer
	output logic      o_finished,  // All commands acknowledged
	output logic      o_error      // Retries exhausted
);

	localparam int RW = (MAX_RETRIES > 0) ? $clog2(MAX_RETRIES + 1) : 1;

	logic          active, active_nxt;  // Run in progress
	cmd_idx_t      idx, idx_nxt;        // Current command
	logic [RW-1:0] retry, retry_nxt;    // Resends used on this command
	logic          send_r, send_nxt;
	logic          fin_r, fin_nxt;
	logic          err_r, err_nxt;

	assign o_send     = send_r;
	assign o_word     = CODEC_CMDS[idx];  // Stable while the word is in flight
	assign o_finished = fin_r;
	assign o_error    = err_r;

	always_comb begin
		active_nxt = active;
		idx_nxt    = idx;
		retry_nxt  = retry;
		send_nxt   = 1'b0;
		fin_nxt    = fin_r;
		err_nxt    = err_r;

		if (!active) begin
			if (i_start) begin
				active_nxt = 1'b1;
				idx_nxt    = '0;  // Always from the top
				retry_nxt  = '0;
				fin_nxt    = 1'b0;
				err_nxt    = 1'b0;
				send_nxt   = 1'b1;
			end
		end
		else if (i_done) begin
			if (!i_nack) begin
				retry_nxt = '0;
				if (idx == cmd_idx_t'(NUM_CMDS - 1)) begin
					fin_nxt    = 1'b1;  // Last entry acknowledged
					active_nxt = 1'b0;
				end
				else begin
					idx_nxt  = idx + 1'b1;
					send_nxt = 1'b1;
				end
			end
			else if (retry < RW'(MAX_RETRIES)) begin
				retry_nxt = retry + 1'b1;
				send_nxt  = 1'b1;  // Same word again
			end
			else begin
				err_nxt    = 1'b1;  // Give up, no later command
				active_nxt = 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active <= 1'b0;
			idx    <= '0;
			retry  <= '0;
			send_r <= 1'b0;
			fin_r  <= 1'b0;
			err_r  <= 1'b0;
		end
		else begin
			active <= active_nxt;
			idx    <= idx_nxt;
			retry  <= retry_nxt;
			send_r <= send_nxt;
			fin_r  <= fin_nxt;
			err_r  <= err_nxt;
		end
	end

endmodule

//--- logic/codec_init.sv
module codec_init import codec_init_pkg::*; #(
	parameter int CLK_DIV     = 4,  // Cycles per quarter bit
	parameter int MAX_RETRIES = 2   // Resends per command
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,     // Kick off a bring-up run
	input  logic i_ack,       // Data line as seen on the bus
	output logic o_sclk,
	output logic o_sdat,
	output logic o_oen,       // SDA output enable
	output logic o_finished,
	output logic o_error
);

	logic      sq_send;  // Sequencer strobe
	cmd_word_t sq_word;  // Word for the writer
	logic      wr_done;  // Writer pulse after stop
	logic      wr_nack;  // Any ack slot refused
	logic      wr_busy;  // Gates the timer
	logic      qt_tick;  // Quarter-bit pacing

	init_sequencer #(
		.MAX_RETRIES (MAX_RETRIES)
	) seq0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_done     (wr_done),
		.i_nack     (wr_nack),
		.o_send     (sq_send),
		.o_word     (sq_word),
		.o_finished (o_finished),
		.o_error    (o_error)
	);

	i2c_word_writer wr0 (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_send  (sq_send),
		.i_word  (sq_word),
		.i_tick  (qt_tick),
		.i_ack   (i_ack),
		.o_busy  (wr_busy),
		.o_done  (wr_done),
		.o_nack  (wr_nack),
		.o_sclk  (o_sclk),
		.o_sdat  (o_sdat),
		.o_oen   (o_oen)
	);

	i2c_quarter_timer #(
		.CLK_DIV (CLK_DIV)
	) qt0 (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_run   (wr_busy),
		.o_tick  (qt_tick)
	);

endmodule

//--- tb/codec_init_properties.sv
module codec_init_properties import codec_init_pkg::*; (
	input logic      i_clk,
	input logic      i_rst_n,
	input logic      i_sclk,      // Bus clock line
	input logic      i_sdat,      // Driven data level
	input logic      i_oen,       // Data output enable
	input logic      i_finished,
	input logic      i_error,
	input logic      i_busy,      // Writer has a word in flight
	input wr_state_t i_state      // Writer FSM state
);

	logic sda_bad  = 1'b0;  // Sticky, SDA moved with SCL high
	logic flag_bad = 1'b0;  // Sticky, both end flags high
	logic oen_bad  = 1'b0;  // Sticky, bus not at rest while idle

	// SDA may only move under a high SCL for start and stop
	a_sda_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		($past(i_sclk) && i_sclk && (i_sdat != $past(i_sdat)))
		|-> ($past(i_state) == WR_START || $past(i_state) == WR_STOP_HI))
	else begin
		sda_bad = 1'b1;
		$error("SDA changed while SCL high outside start or stop");
	end

	a_one_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_finished && i_error))
	else begin
		flag_bad = 1'b1;
		$error("Finished and error flags high together");
	end

	// Line released and both wires high whenever no word is on the bus
	a_idle_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_busy |-> (!i_oen && i_sclk && i_sdat))
	else begin
		oen_bad = 1'b1;
		$error("Bus not released and high while writer idle");
	end

endmodule

//--- tb/codec_init_tb.sv
module codec_init_tb import codec_init_pkg::*; ();

	localparam int CLK_DIV     = 2;    // Fast bus, two cycles per quarter
	localparam int MAX_RETRIES = 2;
	localparam int NUM_ROWS    = 7;
	localparam int WORD_CYCLES = 240;  // One framed word plus strobe slack
	localparam int QUIET       = 250;  // Longer than a word, catches stray frames

	// Register list the codec expects, in bring-up order
	localparam cmd_word_t EXP_CMDS [NUM_CMDS] = '{
		24'h341E00, 24'h340097, 24'h340297, 24'h340479,
		24'h340679, 24'h340815, 24'h340A00, 24'h340C00,
		24'h340E42, 24'h341019, 24'h341201
	};

	typedef struct packed {
		int refuse_idx;  // Command the codec refuses
		int refusals;    // Attempts refused in a row
		bit mid_start;   // Extra start pulse while busy
		bit exp_error;   // 1 ends in o_error, 0 in o_finished
	} row_t;

	localparam row_t ROWS [NUM_ROWS] = '{
		'{0,  0, 1'b0, 1'b0},  // Clean run
		'{3,  1, 1'b0, 1'b0},  // One resend of command 3
		'{5,  3, 1'b0, 1'b1},  // Retries used up on command 5
		'{0,  0, 1'b1, 1'b0},  // Restart after error, extra start mid-run
		'{0,  2, 1'b0, 1'b0},  // Last allowed resend gets through
		'{10, 3, 1'b0, 1'b1},  // Final command never acknowledged
		'{0,  0, 1'b1, 1'b0}   // Clean again after error
	};

	logic i_clk = 1'b0;
	logic i_rst_n;
	logic i_start;
	logic i_ack = 1'b1;  // Pulled-up line until the codec answers
	logic o_sclk;
	logic o_sdat;
	logic o_oen;
	logic o_finished;
	logic o_error;
	logic prop_bad;      // Any bound bus assertion fired

	logic [7:0] lfsr = 8'd76;
	int         cycles = 0;
	int         limit = 0;
	int         row_sel = 0;  // Row the codec model follows

	// Codec model state
	cmd_word_t  cap_q [$];      // Every completed frame, in bus order
	cmd_word_t  exp_q [$];      // Frames expected for the current row
	cmd_word_t  shift;
	logic       prev_scl = 1'b1;
	logic       prev_sda = 1'b1;
	logic       in_frame = 1'b0;
	logic       refuse_now = 1'b0;
	int         bit_pos = 0;
	int         acked = 0;      // Commands acknowledged this row
	int         refused = 0;    // Refusals handed out this row
	int         model_row = 0;

	codec_init #(
		.CLK_DIV     (CLK_DIV),
		.MAX_RETRIES (MAX_RETRIES)
	) dut0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_start),
		.i_ack      (i_ack),
		.o_sclk     (o_sclk),
		.o_sdat     (o_sdat),
		.o_oen      (o_oen),
		.o_finished (o_finished),
		.o_error    (o_error)
	);

	bind codec_init codec_init_properties props0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_sclk     (o_sclk),
		.i_sdat     (o_sdat),
		.i_oen      (o_oen),
		.i_finished (o_finished),
		.i_error    (o_error),
		.i_busy     (wr_busy),
		.i_state    (wr0.state)
	);

	assign prop_bad = dut0.props0.sda_bad | dut0.props0.flag_bad | dut0.props0.oen_bad;

	task automatic report_error(input string msg);
		$display("[ERROR] %0t %s", $time, msg);
		$display("test failed");
		$fatal(1, "check failed");
	endtask

	// Fibonacci LFSR, taps 8 6 5 4, one step per bit taken
	function automatic int draw_bits(input int n);
		int v;
		v = 0;
		repeat (n) begin
			v = (v << 1) | int'(lfsr[7]);
			lfsr = {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
		end
		return v;
	endfunction

	initial begin
		forever #20 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: the run did not end within %0d cycles", limit);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	// Codec model, sampled on the falling edge where the bus is settled
	always @(negedge i_clk) begin
		if (!i_rst_n) begin
			prev_scl  = 1'b1;
			prev_sda  = 1'b1;
			in_frame  = 1'b0;
			acked     = 0;
			refused   = 0;
			model_row = row_sel;
			i_ack     = 1'b1;
		end
		else begin
			if (row_sel != model_row) begin
				model_row = row_sel;  // New scenario, fresh counts
				acked     = 0;
				refused   = 0;
			end
			if (prev_scl && o_sclk && prev_sda && !o_sdat) begin
				in_frame   = 1'b1;  // Start condition
				bit_pos    = 0;
				shift      = '0;
				refuse_now = (acked == ROWS[model_row].refuse_idx) &&
					(refused < ROWS[model_row].refusals);
			end
			else if (prev_scl && o_sclk && !prev_sda && o_sdat && in_frame) begin
				assert (bit_pos == 28)  // 24 data bits, 3 ack slots and the stop pulse
				else report_error($sformatf("frame had %0d clock pulses", bit_pos));
				cap_q.push_back(shift);
				if (refuse_now) begin
					refused++;
				end
				else begin
					acked++;
				end
				in_frame = 1'b0;
			end
			else if (!prev_scl && o_sclk && in_frame) begin
				if (bit_pos < 27 && bit_pos % 9 != 8) begin
					shift = {shift[CMD_WIDTH-2:0], o_sdat};  // Skip ack slots and stop pulse
				end
				bit_pos++;
			end
			// Answer only while the line is released inside a frame
			i_ack    = (in_frame && !o_oen) ? refuse_now : 1'b1;
			prev_scl = o_sclk;
			prev_sda = o_sdat;
		end
	end

	always @(negedge i_clk) begin
		assert (!prop_bad) else report_error("bus property assertion failed");
	end

	initial begin
		int dly;
		int base;
		int tries;

		for (int r = 0; r < NUM_ROWS; r++) begin
			limit += (NUM_CMDS + ROWS[r].refusals) * WORD_CYCLES;
		end
		limit += NUM_ROWS * 400 + 100;  // Delays, quiet windows, reset
		i_rst_n = 1'b0;
		i_start = 1'b0;
		repeat (4) @(negedge i_clk);
		i_rst_n = 1'b1;

		for (int r = 0; r < NUM_ROWS; r++) begin
			row_sel = r;
			dly = draw_bits(4);
			repeat (dly + 1) @(negedge i_clk);
			assert (!o_oen && o_sclk && o_sdat)
			else report_error("bus not idle before start");

			// Frames the rules predict for this row
			exp_q.delete();
			for (int c = 0; c < NUM_CMDS; c++) begin
				if (c == ROWS[r].refuse_idx && ROWS[r].refusals != 0) begin
					tries = (ROWS[r].refusals > MAX_RETRIES) ? MAX_RETRIES + 1 :
						ROWS[r].refusals + 1;
					repeat (tries) exp_q.push_back(EXP_CMDS[c]);
					if (ROWS[r].refusals > MAX_RETRIES) begin
						break;  // Error ends the run here
					end
				end
				else begin
					exp_q.push_back(EXP_CMDS[c]);
				end
			end

			base = cap_q.size();
			i_start = 1'b1;
			@(negedge i_clk);
			i_start = 1'b0;
			assert (!o_finished && !o_error)
			else report_error("end flags not cleared by start");

			if (ROWS[r].mid_start) begin
				while (cap_q.size() < base + 2) @(negedge i_clk);
				repeat (60) @(negedge i_clk);  // Land inside a word
				i_start = 1'b1;
				@(negedge i_clk);
				i_start = 1'b0;
			end

			while (!o_finished && !o_error) @(negedge i_clk);
			assert (o_error == ROWS[r].exp_error && o_finished == !ROWS[r].exp_error)
			else report_error($sformatf("row %0d ended finished=%b error=%b",
				r, o_finished, o_error));
			assert (cap_q.size() - base == exp_q.size())
			else report_error($sformatf("row %0d captured %0d frames, expected %0d",
				r, cap_q.size() - base, exp_q.size()));
			for (int k = 0; k < exp_q.size(); k++) begin
				assert (cap_q[base + k] == exp_q[k])
				else report_error($sformatf("row %0d frame %0d got %h expected %h",
					r, k, cap_q[base + k], exp_q[k]));
			end

			// Nothing more may go out once the run has ended
			repeat (QUIET) @(negedge i_clk);
			assert (cap_q.size() - base == exp_q.size())
			else report_error("frame sent after the run ended");
			assert (!o_oen && o_sclk && o_sdat)
			else report_error("bus not idle after the run");
		end

		if (!prop_bad) begin
			$display("test passed");
			$finish;
		end
		else begin
			$display("test failed");
			$fatal(1, "bus property assertion failed");
		end
	end

endmodule

//--- codec_init.f
logic/codec_init_pkg.sv
logic/i2c_quarter_timer.sv
logic/i2c_word_writer.sv
logic/init_sequencer.sv
logic/codec_init.sv
tb/codec_init_properties.sv
tb/codec_init_tb.sv

//--- Makefile
# Verilator build and run for the codec bring-up testbench
TOP = codec_init_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f codec_init.f --top-module $(TOP)

# The run passes only if the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
